/* ddr_pkg.sv */
// Shared types and constants for the DDR4 user-clock subsystem
// Data path is one 64-bit word per command with no bursts
// Application mask is active high: a set bit keeps the byte unchanged
// Wishbone select is active high: a set bit writes the byte
package ddr_pkg;

  //**************************************************
  // Data path widths
  //**************************************************
  localparam int DATA_W = 64;
  localparam int BYTES  = DATA_W / 8;

  // One memory word, same on host and application side
  typedef logic [DATA_W-1:0] data_t;

  // Application byte mask, set bit means byte is not written
  typedef logic [BYTES-1:0] mask_t;

  // Wishbone byte select, set bit means byte is written
  typedef logic [BYTES-1:0] sel_t;

  //**************************************************
  // Application command codes
  //**************************************************
  typedef logic [2:0] app_cmd_t;

  localparam app_cmd_t CMD_WRITE = 3'd0;
  localparam app_cmd_t CMD_READ  = 3'd1;

  //**************************************************
  // Self-test pattern
  //**************************************************
  // Word i holds its zero-extended word address XOR this key
  localparam data_t SELFTEST_KEY = 64'ha5c3_96e1_0f5a_d27b;

endpackage

/* app_if.sv */
// Memory-controller application port, single word per command
// Write data travels with its command; there is no separate wdf_rdy
// The controller side must always accept read return data
`timescale 1ns/1ps

interface app_if import ddr_pkg::*; #(
  parameter int ADDR_W = 10
) ();

  // Command channel
  logic [ADDR_W-1:0] addr;
  app_cmd_t          cmd;
  logic              en;
  logic              rdy;

  // Write data, valid with the command
  data_t             wdf_data;
  mask_t             wdf_mask;
  logic              wdf_wren;

  // Read return, in order
  data_t             rd_data;
  logic              rd_data_valid;

  modport controller (
    output addr, cmd, en, wdf_data, wdf_mask, wdf_wren,
    input  rdy, rd_data, rd_data_valid
  );

  modport memory (
    input  addr, cmd, en, wdf_data, wdf_mask, wdf_wren,
    output rdy, rd_data, rd_data_valid
  );

endinterface

/* wb_app_bridge.sv */
// Wishbone classic slave to application command bridge
// One outstanding transfer; the host must hold its signals until ack
// Ack is a single cycle and the host drops stb in the next cycle
// Read data on wb_dat_o is only meaningful while wb_ack_o is high
`timescale 1ns/1ps

module wb_app_bridge import ddr_pkg::*; #(
  parameter int ADDR_W = 10
) (
  input  logic              c0_ddr4_clk,
  input  logic              reset_i,
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  logic [ADDR_W-1:0] wb_adr_i,
  input  data_t             wb_dat_i,
  input  sel_t              wb_sel_i,
  output data_t             wb_dat_o,
  output logic              wb_ack_o,
  app_if.controller         app
);

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT_RD,
    ACK
  } state_t;

  state_t            state_q;
  logic              req;
  logic              accept;

  // Latched host request
  logic [ADDR_W-1:0] addr_q;
  app_cmd_t          cmd_q;
  data_t             wdata_q;
  mask_t             mask_q;
  data_t             rdata_q;

  assign req    = wb_cyc_i && wb_stb_i;
  assign accept = app.en && app.rdy;

  //**************************************************
  // Transfer FSM
  //**************************************************
  always_ff @(posedge c0_ddr4_clk) begin
    if (reset_i) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE: begin
          if (req) state_q <= ISSUE;
        end
        ISSUE: begin
          // Writes complete on acceptance, reads wait for return data
          if (accept) begin
            if (cmd_q == CMD_WRITE) state_q <= ACK;
            else                    state_q <= WAIT_RD;
          end
        end
        WAIT_RD: begin
          if (app.rd_data_valid) state_q <= ACK;
        end
        ACK:     state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // Request and read data capture
  always_ff @(posedge c0_ddr4_clk) begin
    if (state_q == IDLE && req) begin
      addr_q  <= wb_adr_i;
      cmd_q   <= wb_we_i ? CMD_WRITE : CMD_READ;
      wdata_q <= wb_dat_i;
      // Mask bits mark the bytes to leave unchanged
      mask_q  <= ~wb_sel_i;
    end
    if (state_q == WAIT_RD && app.rd_data_valid) begin
      rdata_q <= app.rd_data;
    end
  end

  //**************************************************
  // Application side
  //**************************************************
  // en stays high through back-pressure until accepted
  assign app.en       = (state_q == ISSUE);
  assign app.addr     = addr_q;
  assign app.cmd      = cmd_q;
  assign app.wdf_data = wdata_q;
  assign app.wdf_mask = mask_q;
  assign app.wdf_wren = (state_q == ISSUE) && (cmd_q == CMD_WRITE);

  // Host side
  assign wb_ack_o = (state_q == ACK);
  assign wb_dat_o = rdata_q;

endmodule

/* ddr_selftest.sv */
// In-line power-up memory test between host bridge and controller
// Writes SELFTEST_WORDS words from address 0 after calibration, then
// reads them back; word i is its address XOR SELFTEST_KEY
// Host traffic is held off until done, then passes straight through
// Compare error is sticky until reset
`timescale 1ns/1ps

module ddr_selftest import ddr_pkg::*; #(
  parameter int ADDR_W         = 10,
  parameter int SELFTEST_WORDS = 16
) (
  input  logic      c0_ddr4_clk,
  input  logic      reset_i,
  input  logic      calib_complete_i,
  app_if.memory     up,
  app_if.controller dn,
  output logic      selftest_done_o,
  output logic      compare_error_o
);

  localparam int CNT_W = $clog2(SELFTEST_WORDS + 1);
  localparam logic [CNT_W-1:0] LAST_IDX = CNT_W'(SELFTEST_WORDS - 1);

  typedef enum logic [2:0] {
    WAIT_CAL,
    WRITE,
    READ,
    DRAIN,
    PASS
  } state_t;

  state_t            state_q;
  logic [CNT_W-1:0]  iss_cnt_q;
  logic [CNT_W-1:0]  ret_cnt_q;
  logic [ADDR_W-1:0] iss_addr;
  logic [ADDR_W-1:0] ret_addr;
  logic              sel_host;
  logic              st_accept;
  logic              st_return;
  logic              err_q;

  function automatic data_t st_pattern(input logic [ADDR_W-1:0] a);
    return data_t'(a) ^ SELFTEST_KEY;
  endfunction

  assign iss_addr  = ADDR_W'(iss_cnt_q);
  assign ret_addr  = ADDR_W'(ret_cnt_q);
  assign sel_host  = (state_q == PASS);
  assign st_accept = !sel_host && dn.en && dn.rdy;
  assign st_return = !sel_host && dn.rd_data_valid;

  //**************************************************
  // Test sequencer
  //**************************************************
  always_ff @(posedge c0_ddr4_clk) begin
    if (reset_i) begin
      state_q   <= WAIT_CAL;
      iss_cnt_q <= '0;
    end else begin
      case (state_q)
        WAIT_CAL: begin
          if (calib_complete_i) state_q <= WRITE;
        end
        WRITE, READ: begin
          if (st_accept) begin
            if (iss_cnt_q == LAST_IDX) begin
              iss_cnt_q <= '0;
              state_q   <= (state_q == WRITE) ? READ : DRAIN;
            end else begin
              iss_cnt_q <= iss_cnt_q + 1'b1;
            end
          end
        end
        DRAIN: begin
          // Switch over right after the last word is back
          if (st_return && ret_cnt_q == LAST_IDX) state_q <= PASS;
        end
        PASS:    state_q <= PASS;
        default: state_q <= WAIT_CAL;
      endcase
    end
  end

  // Return side runs on its own index, reads may overlap
  always_ff @(posedge c0_ddr4_clk) begin
    if (reset_i) begin
      ret_cnt_q <= '0;
      err_q     <= 1'b0;
    end else if (st_return) begin
      ret_cnt_q <= ret_cnt_q + 1'b1;
      if (dn.rd_data != st_pattern(ret_addr)) err_q <= 1'b1;
    end
  end

  //**************************************************
  // Downstream multiplexer
  //**************************************************
  always_comb begin
    if (sel_host) begin
      dn.addr     = up.addr;
      dn.cmd      = up.cmd;
      dn.en       = up.en;
      dn.wdf_data = up.wdf_data;
      dn.wdf_mask = up.wdf_mask;
      dn.wdf_wren = up.wdf_wren;
    end else begin
      dn.addr     = iss_addr;
      dn.cmd      = (state_q == WRITE) ? CMD_WRITE : CMD_READ;
      dn.en       = (state_q == WRITE) || (state_q == READ);
      dn.wdf_data = st_pattern(iss_addr);
      dn.wdf_mask = '0;
      dn.wdf_wren = (state_q == WRITE);
    end
  end

  // Upstream sees a stalled, silent port until the test is over
  assign up.rdy           = sel_host && dn.rdy;
  assign up.rd_data       = dn.rd_data;
  assign up.rd_data_valid = sel_host && dn.rd_data_valid;

  assign selftest_done_o = sel_host;
  assign compare_error_o = err_q;

endmodule

/* ddr_app_model.sv */
// Behavioral stand-in for the DDR4 controller, PHY and memory
// Calibration completes CALIB_CYCLES cycles after reset release
// rdy drops one cycle in eight after calibration
// Reads return after exactly RD_LAT cycles, RD_LAT must be at least 1
// Memory holds 2**ADDR_W words with no initial contents
`timescale 1ns/1ps

module ddr_app_model import ddr_pkg::*; #(
  parameter int ADDR_W       = 10,
  parameter int CALIB_CYCLES = 64,
  parameter int RD_LAT       = 4
) (
  input  logic  c0_ddr4_clk,
  input  logic  reset_i,
  app_if.memory app,
  output logic  calib_complete_o
);

  localparam int DEPTH   = 2 ** ADDR_W;
  localparam int CAL_W   = $clog2(CALIB_CYCLES + 1);
  localparam logic [CAL_W-1:0] CAL_LAST = CAL_W'(CALIB_CYCLES);

  logic [CAL_W-1:0] calib_cnt_q;
  logic             calib_q;
  logic [2:0]       bp_cnt_q;
  logic             accept;
  logic             wr_acc;
  logic             rd_acc;

  data_t            mem [DEPTH];

  // Read latency pipeline
  logic             rd_vld_q [RD_LAT];
  data_t            rd_dat_q [RD_LAT];

  assign accept = app.en && app.rdy;
  assign wr_acc = accept && (app.cmd == CMD_WRITE) && app.wdf_wren;
  assign rd_acc = accept && (app.cmd == CMD_READ);

  //**************************************************
  // Calibration and back-pressure
  //**************************************************
  always_ff @(posedge c0_ddr4_clk) begin
    if (reset_i) begin
      calib_cnt_q <= '0;
      calib_q     <= 1'b0;
    end else if (!calib_q) begin
      if (calib_cnt_q == CAL_LAST) calib_q <= 1'b1;
      else                         calib_cnt_q <= calib_cnt_q + 1'b1;
    end
  end

  // Free-running, refuses a command every eighth cycle
  always_ff @(posedge c0_ddr4_clk) begin
    if (reset_i) begin
      bp_cnt_q <= '0;
    end else begin
      bp_cnt_q <= bp_cnt_q + 1'b1;
    end
  end

  assign app.rdy          = calib_q && (bp_cnt_q != 3'd7);
  assign calib_complete_o = calib_q;

  //**************************************************
  // Word storage with byte mask
  //**************************************************
  always_ff @(posedge c0_ddr4_clk) begin
    if (wr_acc) begin
      for (int b = 0; b < BYTES; b++) begin
        if (!app.wdf_mask[b]) mem[app.addr][b*8 +: 8] <= app.wdf_data[b*8 +: 8];
      end
    end
  end

  //**************************************************
  // Read return pipeline
  //**************************************************
  always_ff @(posedge c0_ddr4_clk) begin
    if (reset_i) begin
      for (int s = 0; s < RD_LAT; s++) begin
        rd_vld_q[s] <= 1'b0;
      end
    end else begin
      rd_vld_q[0] <= rd_acc;
      for (int s = 1; s < RD_LAT; s++) begin
        rd_vld_q[s] <= rd_vld_q[s-1];
      end
    end
  end

  // Word is sampled at acceptance, then only shifted
  always_ff @(posedge c0_ddr4_clk) begin
    rd_dat_q[0] <= mem[app.addr];
    for (int s = 1; s < RD_LAT; s++) begin
      rd_dat_q[s] <= rd_dat_q[s-1];
    end
  end

  assign app.rd_data       = rd_dat_q[RD_LAT-1];
  assign app.rd_data_valid = rd_vld_q[RD_LAT-1];

endmodule

/* ddr_subsys_top.sv */
// DDR4 subsystem in the c0_ddr4_clk domain, single clock
// Wishbone classic host port -> self-test -> controller stand-in
// Host cycles stall until selftest_done_o is high
// SELFTEST_WORDS must not exceed 2**ADDR_W
`timescale 1ns/1ps

module ddr_subsys_top import ddr_pkg::*; #(
  parameter int ADDR_W         = 10,
  parameter int CALIB_CYCLES   = 64,
  parameter int RD_LAT         = 4,
  parameter int SELFTEST_WORDS = 16
) (
  input  logic              c0_ddr4_clk,
  input  logic              reset_i,
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  logic [ADDR_W-1:0] wb_adr_i,
  input  data_t             wb_dat_i,
  input  sel_t              wb_sel_i,
  output data_t             wb_dat_o,
  output logic              wb_ack_o,
  output logic              init_calib_complete_o,
  output logic              selftest_done_o,
  output logic              data_compare_error_o
);

  //**************************************************
  // Application ports
  //**************************************************
  // Bridge to self-test, and self-test to controller
  app_if #(.ADDR_W(ADDR_W)) host_app ();
  app_if #(.ADDR_W(ADDR_W)) mem_app ();

  wb_app_bridge #(
    .ADDR_W (ADDR_W)
  ) u_bridge (
    .c0_ddr4_clk (c0_ddr4_clk),
    .reset_i     (reset_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_sel_i    (wb_sel_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .app         (host_app)
  );

  ddr_selftest #(
    .ADDR_W         (ADDR_W),
    .SELFTEST_WORDS (SELFTEST_WORDS)
  ) u_selftest (
    .c0_ddr4_clk      (c0_ddr4_clk),
    .reset_i          (reset_i),
    .calib_complete_i (init_calib_complete_o),
    .up               (host_app),
    .dn               (mem_app),
    .selftest_done_o  (selftest_done_o),
    .compare_error_o  (data_compare_error_o)
  );

  ddr_app_model #(
    .ADDR_W       (ADDR_W),
    .CALIB_CYCLES (CALIB_CYCLES),
    .RD_LAT       (RD_LAT)
  ) u_mem (
    .c0_ddr4_clk      (c0_ddr4_clk),
    .reset_i          (reset_i),
    .app              (mem_app),
    .calib_complete_o (init_calib_complete_o)
  );

endmodule

/* tb_ddr_subsys.sv */
// Self-checking testbench for the DDR4 subsystem with default parameters
// Expected data comes from a reference memory that is preloaded with the
// self-test rule (word i = address XOR SELFTEST_KEY) and updated per byte select
// Inputs change 0.5 ns after the rising edge and outputs are sampled later in the cycle
// The run is capped at MAX_CYCLES clock cycles
`timescale 1ns/1ps

module tb_ddr_subsys import ddr_pkg::*; ();

  localparam int ADDR_W         = 10;
  localparam int CALIB_CYCLES   = 64;
  localparam int RD_LAT         = 4;
  localparam int SELFTEST_WORDS = 16;
  localparam int DEPTH          = 2 ** ADDR_W;
  localparam int RAND_OPS       = 30;
  localparam int BYTE_OPS       = 8;
  // About 200 cycles for calibration and self-test, then about 100 host
  // transfers at up to 12 cycles each, with ample margin
  localparam int MAX_CYCLES     = 4000;

  logic              c0_ddr4_clk;
  logic              reset_i;
  logic              wb_cyc_i;
  logic              wb_stb_i;
  logic              wb_we_i;
  logic [ADDR_W-1:0] wb_adr_i;
  data_t             wb_dat_i;
  sel_t              wb_sel_i;
  data_t             wb_dat_o;
  logic              wb_ack_o;
  logic              init_calib_complete_o;
  logic              selftest_done_o;
  logic              data_compare_error_o;

  data_t             ref_mem [DEPTH];
  logic [31:0]       lcg_state;
  int                err_cnt;
  int                mon_err_cnt;
  int                chk_cnt;
  int                ack_cnt;
  int                cycle_cnt;
  logic              ack_prev;

  ddr_subsys_top #(
    .ADDR_W         (ADDR_W),
    .CALIB_CYCLES   (CALIB_CYCLES),
    .RD_LAT         (RD_LAT),
    .SELFTEST_WORDS (SELFTEST_WORDS)
  ) UUT (
    .c0_ddr4_clk           (c0_ddr4_clk),
    .reset_i               (reset_i),
    .wb_cyc_i              (wb_cyc_i),
    .wb_stb_i              (wb_stb_i),
    .wb_we_i               (wb_we_i),
    .wb_adr_i              (wb_adr_i),
    .wb_dat_i              (wb_dat_i),
    .wb_sel_i              (wb_sel_i),
    .wb_dat_o              (wb_dat_o),
    .wb_ack_o              (wb_ack_o),
    .init_calib_complete_o (init_calib_complete_o),
    .selftest_done_o       (selftest_done_o),
    .data_compare_error_o  (data_compare_error_o)
  );

  initial begin
    c0_ddr4_clk = 1'b0;
    forever #2 c0_ddr4_clk = ~c0_ddr4_clk;
  end

  //**************************************************
  // Helpers
  //**************************************************
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic data_t rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = next_rand();
    lo = next_rand();
    return {hi, lo};
  endfunction

  task automatic compare_word(input string name, input data_t got, input data_t exp);
    chk_cnt++;
    assert (got === exp) else begin
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic expect_bit(input string name, input logic got, input logic exp);
    chk_cnt++;
    assert (got === exp) else begin
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  // Reference model of a host write applied byte by byte
  task automatic update_ref(input logic [ADDR_W-1:0] a, input data_t d, input sel_t s);
    for (int b = 0; b < BYTES; b++) begin
      if (s[b]) ref_mem[a][b*8 +: 8] = d[b*8 +: 8];
    end
  endtask

  // Ack is sampled mid-cycle
  task automatic finish_transfer();
    @(negedge c0_ddr4_clk);
    while (!wb_ack_o) @(negedge c0_ddr4_clk);
  endtask

  // Host drops stb after the ack cycle and leaves one idle cycle
  task automatic release_bus();
    @(posedge c0_ddr4_clk);
    #0.5;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    @(posedge c0_ddr4_clk);
    #0.5;
  endtask

  task automatic write_word(input logic [ADDR_W-1:0] a, input data_t d, input sel_t s);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b1;
    wb_adr_i = a;
    wb_dat_i = d;
    wb_sel_i = s;
    finish_transfer();
    release_bus();
    update_ref(a, d, s);
  endtask

  task automatic read_and_compare(input logic [ADDR_W-1:0] a);
    data_t got;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b0;
    wb_adr_i = a;
    wb_sel_i = '1;
    finish_transfer();
    got = wb_dat_o;
    release_bus();
    compare_word($sformatf("wb_dat_o @%h", a), got, ref_mem[a]);
  endtask

  task automatic report_test(input int num, input string name, input int err_before);
    if (err_cnt == err_before) $display("test %0d %s: ok", num, name);
    else $display("test %0d %s: %0d errors", num, name, err_cnt - err_before);
  endtask

  //**************************************************
  // Ack protocol monitor for the whole run
  //**************************************************
  always @(negedge c0_ddr4_clk) begin
    if (reset_i) begin
      ack_prev = 1'b0;
    end else begin
      if (wb_ack_o) begin
        ack_cnt++;
        assert (wb_cyc_i && wb_stb_i) else begin
          $display("Ack protocol: wb_ack_o high without cyc and stb");
          err_cnt++;
          mon_err_cnt++;
        end
        assert (!ack_prev) else begin
          $display("Ack protocol: wb_ack_o high for two cycles in a row");
          err_cnt++;
          mon_err_cnt++;
        end
        assert (selftest_done_o) else begin
          $display("Hold-off: wb_ack_o high before the self-test finished");
          err_cnt++;
          mon_err_cnt++;
        end
      end
      ack_prev = wb_ack_o;
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge c0_ddr4_clk);
      cycle_cnt++;
    end
    $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("test failed");
    $finish;
  end

  //**************************************************
  // Test sequence
  //**************************************************
  initial begin
    logic [ADDR_W-1:0] addrs [RAND_OPS];
    logic [ADDR_W-1:0] a;
    logic [31:0]       r;
    data_t             idx_w;
    sel_t              s;
    int                n;
    int                t;
    int                e0;

    reset_i     = 1'b1;
    wb_cyc_i    = 1'b0;
    wb_stb_i    = 1'b0;
    wb_we_i     = 1'b0;
    wb_adr_i    = '0;
    wb_dat_i    = '0;
    wb_sel_i    = '0;
    lcg_state   = 32'h25305afb;
    err_cnt     = 0;
    mon_err_cnt = 0;
    chk_cnt     = 0;
    ack_cnt     = 0;
    ack_prev    = 1'b0;
    for (int i = 0; i < SELFTEST_WORDS; i++) begin
      idx_w        = '0;
      idx_w[31:0]  = i;
      ref_mem[i]   = idx_w ^ SELFTEST_KEY;
    end

    // Test 1 covers status during and after reset and the calibration delay
    e0 = err_cnt;
    repeat (4) @(posedge c0_ddr4_clk);
    @(negedge c0_ddr4_clk);
    expect_bit("wb_ack_o", wb_ack_o, 1'b0);
    expect_bit("selftest_done_o", selftest_done_o, 1'b0);
    expect_bit("data_compare_error_o", data_compare_error_o, 1'b0);
    expect_bit("init_calib_complete_o", init_calib_complete_o, 1'b0);
    repeat (4) @(posedge c0_ddr4_clk);
    #0.5;
    reset_i = 1'b0;
    // First edge with reset low
    @(posedge c0_ddr4_clk);
    #1;
    expect_bit("wb_ack_o", wb_ack_o, 1'b0);
    expect_bit("selftest_done_o", selftest_done_o, 1'b0);
    expect_bit("data_compare_error_o", data_compare_error_o, 1'b0);
    expect_bit("init_calib_complete_o", init_calib_complete_o, 1'b0);
    n = 0;
    while (!init_calib_complete_o && n < 2 * CALIB_CYCLES) begin
      @(posedge c0_ddr4_clk);
      #1;
      n++;
    end
    compare_word("init_calib_complete_o delay", n, CALIB_CYCLES);
    @(posedge c0_ddr4_clk);
    #0.5;
    report_test(1, "reset and calibration", e0);

    // Test 2 issues a host write while the self-test still runs
    e0 = err_cnt;
    expect_bit("selftest_done_o", selftest_done_o, 1'b0);
    write_word(10'h200, rand_word(), '1);
    expect_bit("selftest_done_o", selftest_done_o, 1'b1);
    expect_bit("data_compare_error_o", data_compare_error_o, 1'b0);
    read_and_compare(10'h200);
    report_test(2, "host hold-off", e0);

    // Test 3 reads back the self-test pattern left in memory
    e0 = err_cnt;
    for (int i = 0; i < SELFTEST_WORDS; i++) begin
      read_and_compare(i[ADDR_W-1:0]);
    end
    report_test(3, "self-test readback", e0);

    // Test 4 writes random words and reads them back in reverse order
    // The first eight addresses run past the top and wrap to zero
    e0 = err_cnt;
    for (int i = 0; i < RAND_OPS; i++) begin
      if (i < 8) begin
        t = (DEPTH - 4 + i) % DEPTH;
        a = t[ADDR_W-1:0];
      end else begin
        r = next_rand();
        a = r[ADDR_W-1:0];
      end
      addrs[i] = a;
      write_word(a, rand_word(), '1);
    end
    for (int i = RAND_OPS - 1; i >= 0; i--) begin
      read_and_compare(addrs[i]);
    end
    report_test(4, "random traffic", e0);

    // Test 5 does a full write, a partial overwrite and a read back
    e0 = err_cnt;
    for (int i = 0; i < BYTE_OPS; i++) begin
      r = next_rand();
      a = r[ADDR_W-1:0];
      r = next_rand();
      s = (i == 0) ? 8'h00 : r[7:0];
      write_word(a, rand_word(), '1);
      write_word(a, rand_word(), s);
      read_and_compare(a);
    end
    report_test(5, "byte select", e0);

    // Test 6 collects the monitor results over the whole run
    e0 = err_cnt - mon_err_cnt;
    chk_cnt += ack_cnt;
    if (ack_cnt == 0) begin
      $display("Ack protocol: no acknowledge seen during the run");
      err_cnt++;
    end
    report_test(6, "ack protocol", e0);

    $display("Summary: %0d checks, %0d acks, %0d errors", chk_cnt, ack_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* ddr_subsys.f */
ddr_pkg.sv
app_if.sv
wb_app_bridge.sv
ddr_selftest.sv
ddr_app_model.sv
ddr_subsys_top.sv
tb_ddr_subsys.sv
